// File: hdl/crc_pkg.sv
/*
  Shared types, register map and reset values of the AHB-Lite CRC accelerator
  Imported by the RTL blocks and by the testbench
*/
`default_nettype none

package crc_pkg;

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	// Bus word and CRC word
	typedef logic [31:0] word_t;
	typedef logic [7:0]  byte_t;
	// Register word offset from HADDR[4:2]
	typedef logic [2:0]  reg_addr_t;
	typedef logic [1:0]  htrans_t;
	typedef logic [2:0]  hsize_t;
	// 0 byte, 1 halfword, 2 word
	typedef logic [1:0]  bus_size_t;
	// 0 is 32 bits, 1 is 16, 2 is 8, 3 is 7
	typedef logic [1:0]  poly_size_t;
	// 0 none, 1 per byte, 2 per halfword, 3 per word
	typedef logic [1:0]  rev_in_t;

	////////////////////////////////////////////////////////////
	// Structures
	////////////////////////////////////////////////////////////

	// CR fields as seen by the engine
	typedef struct packed {
		poly_size_t poly_size;
		rev_in_t    rev_in;
		logic       rev_out;
	} crc_cfg_t;

	// One DR write waiting for the engine
	typedef struct packed {
		word_t     data;
		bus_size_t size;
	} buf_entry_t;

	// Register offsets
	localparam reg_addr_t CRC_DR   = 3'h0;
	localparam reg_addr_t CRC_IDR  = 3'h1;
	localparam reg_addr_t CRC_CR   = 3'h2;
	localparam reg_addr_t CRC_INIT = 3'h4;
	localparam reg_addr_t CRC_POL  = 3'h5;

	localparam htrans_t HTRANS_NONSEQ = 2'b10;

	// Reset values
	localparam crc_cfg_t CRC_CR_RST   = '0;
	localparam word_t    CRC_INIT_RST = 32'hFFFF_FFFF;
	localparam word_t    CRC_POL_RST  = 32'h04C1_1DB7;
	localparam byte_t    CRC_IDR_RST  = 8'h00;

	// Engine FSM
	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_LOAD,
		ENG_RUN
	} engine_state_t;

endpackage

`default_nettype wire

// File: hdl/crc_host_interface.sv
/*
  AHB-Lite slave front end of the CRC accelerator
  Registers the address phase, decodes the register map in the data phase,
  holds CR, muxes read data and stalls the master through HREADYOUT
*/
`default_nettype none

module crc_host_interface
(
	input  wire logic                HCLK,
	input  wire logic                HRESETn,
	input  wire crc_pkg::word_t      HADDR,
	input  wire crc_pkg::word_t      HWDATA,
	input  wire crc_pkg::hsize_t     HSIZE,
	input  wire crc_pkg::htrans_t    HTRANS,
	input  wire logic                HWRITE,
	input  wire logic                HSELx,
	input  wire logic                HREADY,
	input  wire crc_pkg::word_t      crc_out,
	input  wire crc_pkg::word_t      crc_init_out,
	input  wire crc_pkg::word_t      crc_poly_out,
	input  wire crc_pkg::byte_t      crc_idr_out,
	input  wire logic                buffer_full,
	input  wire logic                read_wait,
	input  wire logic                reset_pending,
	output crc_pkg::word_t           HRDATA,
	output logic                     HREADYOUT,
	output logic                     HRESP,
	output crc_pkg::word_t           bus_wr,
	output crc_pkg::bus_size_t       bus_size,
	output crc_pkg::crc_cfg_t        cfg,
	output logic                     buffer_write_en,
	output logic                     crc_init_en,
	output logic                     crc_poly_en,
	output logic                     crc_idr_en,
	output logic                     reset_chain
);

	import crc_pkg::*;

	// Registered address phase
	logic      hsel_q;
	htrans_t   htrans_q;
	logic      hwrite_q;
	reg_addr_t haddr_q;
	bus_size_t size_q;

	// Control register
	crc_cfg_t  cr_q;

	logic sample_bus;
	logic xfer_valid;
	logic wr_req;
	logic rd_req;
	logic dr_wr;
	logic dr_rd;
	logic init_wr;
	logic poly_wr;
	logic idr_wr;
	logic cr_wr;

	////////////////////////////////////////////////////////////
	// Address phase pipeline
	////////////////////////////////////////////////////////////

	// A new address phase is accepted only when no data phase is stalled
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_q   <= 1'b0;
			htrans_q <= '0;
		end
		else if (sample_bus)
		begin
			hsel_q   <= HSELx;
			htrans_q <= HTRANS;
		end
	end

	// Address, direction and size only matter while hsel_q is set
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			hwrite_q <= HWRITE;
			haddr_q  <= HADDR[4:2];
			size_q   <= HSIZE[1:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Data phase decode
	////////////////////////////////////////////////////////////

	// Only NONSEQ transfers are acted on
	assign xfer_valid = hsel_q && (htrans_q == HTRANS_NONSEQ);
	assign wr_req     = xfer_valid && hwrite_q;
	assign rd_req     = xfer_valid && !hwrite_q;

	assign dr_wr   = wr_req && (haddr_q == CRC_DR);
	assign dr_rd   = rd_req && (haddr_q == CRC_DR);
	assign init_wr = wr_req && (haddr_q == CRC_INIT);
	assign poly_wr = wr_req && (haddr_q == CRC_POL);
	assign idr_wr  = wr_req && (haddr_q == CRC_IDR);
	assign cr_wr   = wr_req && (haddr_q == CRC_CR);

	// Three stall causes
	assign HREADYOUT = !((dr_wr && buffer_full) ||
	                     (dr_rd && read_wait) ||
	                     (init_wr && reset_pending));

	// No error response in this design
	assign HRESP = 1'b0;

	// Strobes of stallable writes fire only in the last data phase cycle
	assign buffer_write_en = dr_wr && HREADYOUT;
	assign crc_init_en     = init_wr && HREADYOUT;
	// POL, IDR and CR writes never stall
	assign crc_poly_en     = poly_wr;
	assign crc_idr_en      = idr_wr;
	// Bit 0 of CR restarts the chain and is not stored
	assign reset_chain     = cr_wr && HWDATA[0];

	// Write data comes straight from the bus
	assign bus_wr   = HWDATA;
	assign bus_size = size_q;

	////////////////////////////////////////////////////////////
	// Control register and read mux
	////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			cr_q <= CRC_CR_RST;
		end
		else if (cr_wr)
		begin
			cr_q.poly_size <= HWDATA[4:3];
			cr_q.rev_in    <= HWDATA[6:5];
			cr_q.rev_out   <= HWDATA[7];
		end
	end

	assign cfg = cr_q;

	// Read data follows the registered offset
	always_comb
	begin
		case (haddr_q)
			CRC_DR:   HRDATA = crc_out;
			CRC_IDR:  HRDATA = {24'h0, crc_idr_out};
			// CR reads back at the bit positions it was written
			CRC_CR:   HRDATA = {24'h0, cr_q.rev_out, cr_q.rev_in, cr_q.poly_size, 3'b000};
			CRC_INIT: HRDATA = crc_init_out;
			CRC_POL:  HRDATA = crc_poly_out;
			default:  HRDATA = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/crc_data_buffer.sv
/*
  Circular FIFO of DR writes between the AHB side and the CRC engine
  Depth is a power of two; flush empties it in one cycle
*/
`default_nettype none

module crc_data_buffer #(
	parameter int BUF_DEPTH = 2
)
(
	input  wire logic                HCLK,
	input  wire logic                HRESETn,
	input  wire logic                push,
	input  wire crc_pkg::buf_entry_t push_entry,
	input  wire logic                pop,
	input  wire logic                flush,
	output crc_pkg::buf_entry_t      head,
	output logic                     empty,
	output logic                     full
);

	import crc_pkg::*;

	// One pointer bit at least, so a depth of 1 still builds
	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);

	buf_entry_t       mem [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;

	// Pointer advance with wrap at the last slot
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(BUF_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Pointers and fill level
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else if (flush)
		begin
			// Restart drops whatever is waiting
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr_q <= ptr_next(wr_ptr_q);
			if (pop)
				rd_ptr_q <= ptr_next(rd_ptr_q);
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// Storage
	always_ff @(posedge HCLK)
	begin
		if (push)
			mem[wr_ptr_q] <= push_entry;
	end

	assign head  = mem[rd_ptr_q];
	assign empty = (count_q == '0);
	assign full  = (count_q == CNT_W'(BUF_DEPTH));

endmodule

`default_nettype wire

// File: hdl/crc_engine.sv
/*
  Byte-serial CRC engine fed from the data buffer
  Pops one word, reverses its input bits, then folds in one byte per cycle
  Restart reloads the seed from INIT
*/
`default_nettype none

module crc_engine
(
	input  wire logic                HCLK,
	input  wire logic                HRESETn,
	input  wire crc_pkg::crc_cfg_t   cfg,
	input  wire crc_pkg::buf_entry_t head,
	input  wire logic                buffer_empty,
	input  wire logic                reset_chain,
	input  wire crc_pkg::word_t      crc_init_out,
	input  wire crc_pkg::word_t      crc_poly_out,
	output logic                     pop,
	output crc_pkg::word_t           crc_out,
	output logic                     read_wait,
	output logic                     reset_pending
);

	import crc_pkg::*;

	engine_state_t state_q;
	logic [2:0]    bytes_left_q;
	word_t         data_q;
	word_t         crc_q;
	word_t         width_mask;
	word_t         data_rev;
	logic [2:0]    n_bytes;
	int            rev_xor;
	int            out_shift;

	// Mask of the selected polynomial width
	function automatic word_t mask_of(input poly_size_t sz);
		case (sz)
			2'd1:    return 32'h0000_FFFF;
			2'd2:    return 32'h0000_00FF;
			2'd3:    return 32'h0000_007F;
			default: return 32'hFFFF_FFFF;
		endcase
	endfunction

	// MSB-first update of one byte, data bit 7 first
	function automatic word_t crc_step(input word_t crc, input byte_t d, input word_t poly,
	                                   input word_t mask);
		word_t c;
		word_t top;
		logic  fb;
		top = mask & ~(mask >> 1);
		c   = crc;
		for (int i = 7; i >= 0; i--)
		begin
			fb = (|(c & top)) ^ d[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	////////////////////////////////////////////////////////////
	// Input side
	////////////////////////////////////////////////////////////

	assign width_mask = mask_of(cfg.poly_size);

	// Bit index flip for byte, halfword or word reversal
	always_comb
	begin
		case (cfg.rev_in)
			2'd1:    rev_xor = 7;
			2'd2:    rev_xor = 15;
			2'd3:    rev_xor = 31;
			default: rev_xor = 0;
		endcase
		for (int i = 0; i < 32; i++)
			data_rev[i] = head.data[i ^ rev_xor];
	end

	// Bytes carried by the head entry
	always_comb
	begin
		case (head.size)
			2'd0:    n_bytes = 3'd1;
			2'd1:    n_bytes = 3'd2;
			default: n_bytes = 3'd4;
		endcase
	end

	// Take the head only when idle and no restart is under way
	assign pop = (state_q == ENG_IDLE) && !buffer_empty && !reset_chain;

	////////////////////////////////////////////////////////////
	// FSM and CRC register
	////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state_q      <= ENG_IDLE;
			bytes_left_q <= '0;
			crc_q        <= CRC_INIT_RST;
		end
		else if (reset_chain)
		begin
			// Current word is dropped along with the buffer
			state_q <= ENG_LOAD;
		end
		else
		begin
			case (state_q)
				ENG_LOAD:
				begin
					crc_q   <= crc_init_out & width_mask;
					state_q <= ENG_IDLE;
				end
				ENG_IDLE:
				begin
					if (pop)
					begin
						bytes_left_q <= n_bytes;
						state_q      <= ENG_RUN;
					end
				end
				ENG_RUN:
				begin
					crc_q        <= crc_step(crc_q, data_q[7:0], crc_poly_out, width_mask);
					bytes_left_q <= bytes_left_q - 1'b1;
					if (bytes_left_q == 3'd1)
						state_q <= ENG_IDLE;
				end
				default: state_q <= ENG_IDLE;
			endcase
		end
	end

	// Word under work, lowest byte first
	always_ff @(posedge HCLK)
	begin
		if (pop)
			data_q <= data_rev;
		else if (state_q == ENG_RUN)
			data_q <= data_q >> 8;
	end

	////////////////////////////////////////////////////////////
	// Output side
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (cfg.poly_size)
			2'd1:    out_shift = 16;
			2'd2:    out_shift = 24;
			2'd3:    out_shift = 25;
			default: out_shift = 0;
		endcase
	end

	// Reversal spans only the selected width
	assign crc_out = cfg.rev_out ? ({<<{crc_q & width_mask}} >> out_shift)
	                             : (crc_q & width_mask);

	// DR reads hold off until every buffered word is folded in
	assign read_wait     = !buffer_empty || (state_q != ENG_IDLE);
	assign reset_pending = (state_q == ENG_LOAD);

endmodule

`default_nettype wire

// File: hdl/crc_config_regs.sv
/*
  Storage for INIT, POL and IDR
  Written from the unregistered bus data on the host interface strobes
*/
`default_nettype none

module crc_config_regs
(
	input  wire logic           HCLK,
	input  wire logic           HRESETn,
	input  wire crc_pkg::word_t bus_wr,
	input  wire logic           crc_init_en,
	input  wire logic           crc_poly_en,
	input  wire logic           crc_idr_en,
	output crc_pkg::word_t      crc_init_out,
	output crc_pkg::word_t      crc_poly_out,
	output crc_pkg::byte_t      crc_idr_out
);

	import crc_pkg::*;

	// Seed picked up by the engine on restart
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_init_out <= CRC_INIT_RST;
		else if (crc_init_en)
			crc_init_out <= bus_wr;
	end

	// Full 32 bits kept; the engine masks to the selected width
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_poly_out <= CRC_POL_RST;
		else if (crc_poly_en)
			crc_poly_out <= bus_wr;
	end

	// Scratch byte with no effect on the CRC
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_idr_out <= CRC_IDR_RST;
		else if (crc_idr_en)
			crc_idr_out <= bus_wr[7:0];
	end

endmodule

`default_nettype wire

// File: hdl/crc_ahb_top.sv
/*
  Top level of the AHB-Lite CRC accelerator
  Wires the host interface to the data buffer, CRC engine and config registers
*/
`default_nettype none

module crc_ahb_top #(
	parameter int BUF_DEPTH = 2
)
(
	input  wire logic             HCLK,
	input  wire logic             HRESETn,
	input  wire crc_pkg::word_t   HADDR,
	input  wire crc_pkg::word_t   HWDATA,
	input  wire crc_pkg::hsize_t  HSIZE,
	input  wire crc_pkg::htrans_t HTRANS,
	input  wire logic             HWRITE,
	input  wire logic             HSELx,
	input  wire logic             HREADY,
	output crc_pkg::word_t        HRDATA,
	output logic                  HREADYOUT,
	output logic                  HRESP
);

	import crc_pkg::*;

	// Host interface to datapath
	word_t      bus_wr;
	bus_size_t  bus_size;
	crc_cfg_t   cfg;
	logic       buffer_write_en;
	logic       crc_init_en;
	logic       crc_poly_en;
	logic       crc_idr_en;
	logic       reset_chain;

	// Buffer and engine
	buf_entry_t buf_head;
	logic       buffer_full;
	logic       buffer_empty;
	logic       buffer_pop;
	logic       read_wait;
	logic       reset_pending;

	// Register values
	word_t      crc_out;
	word_t      crc_init_out;
	word_t      crc_poly_out;
	byte_t      crc_idr_out;

	crc_host_interface i_host_interface (
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HADDR           (HADDR),
		.HWDATA          (HWDATA),
		.HSIZE           (HSIZE),
		.HTRANS          (HTRANS),
		.HWRITE          (HWRITE),
		.HSELx           (HSELx),
		.HREADY          (HREADY),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.buffer_full     (buffer_full),
		.read_wait       (read_wait),
		.reset_pending   (reset_pending),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.cfg             (cfg),
		.buffer_write_en (buffer_write_en),
		.crc_init_en     (crc_init_en),
		.crc_poly_en     (crc_poly_en),
		.crc_idr_en      (crc_idr_en),
		.reset_chain     (reset_chain)
	);

	// Each entry is the bus word with its transfer size
	crc_data_buffer #(
		.BUF_DEPTH (BUF_DEPTH)
	) i_data_buffer (
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.push       (buffer_write_en),
		.push_entry ({bus_wr, bus_size}),
		.pop        (buffer_pop),
		.flush      (reset_chain),
		.head       (buf_head),
		.empty      (buffer_empty),
		.full       (buffer_full)
	);

	crc_engine i_engine (
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.cfg           (cfg),
		.head          (buf_head),
		.buffer_empty  (buffer_empty),
		.reset_chain   (reset_chain),
		.crc_init_out  (crc_init_out),
		.crc_poly_out  (crc_poly_out),
		.pop           (buffer_pop),
		.crc_out       (crc_out),
		.read_wait     (read_wait),
		.reset_pending (reset_pending)
	);

	crc_config_regs i_config_regs (
		.HCLK         (HCLK),
		.HRESETn      (HRESETn),
		.bus_wr       (bus_wr),
		.crc_init_en  (crc_init_en),
		.crc_poly_en  (crc_poly_en),
		.crc_idr_en   (crc_idr_en),
		.crc_init_out (crc_init_out),
		.crc_poly_out (crc_poly_out),
		.crc_idr_out  (crc_idr_out)
	);

endmodule

`default_nettype wire

// File: testbench/crc_ahb_assert.sv
/*
  Protocol checks on the AHB host interface of the CRC accelerator
  Bound into crc_host_interface from the testbench top
*/
`default_nettype none

module crc_ahb_assert
(
	input wire logic             HCLK,
	input wire logic             HRESETn,
	input wire logic             HRESP,
	input wire logic             HREADYOUT,
	input wire logic             HREADY,
	input wire logic             HSELx,
	input wire crc_pkg::htrans_t HTRANS,
	input wire logic             HWRITE,
	input wire crc_pkg::word_t   HADDR,
	input wire logic             reset_chain
);

	timeunit 1ns;
	timeprecision 100ps;

	import crc_pkg::*;

	// Slave never signals an error
	hresp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
		HRESP == 1'b0)
		else $error("HRESP is not OKAY");

	// Data phase of anything but a selected NONSEQ never stalls
	ready_when_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(HREADY && HREADYOUT && !(HSELx && (HTRANS == HTRANS_NONSEQ))) |=> HREADYOUT)
		else $error("HREADYOUT low without a selected NONSEQ data phase");

	// Restart only in the data phase of an accepted CR write
	restart_from_cr: assert property (@(posedge HCLK) disable iff (!HRESETn)
		reset_chain |-> $past(HREADY && HREADYOUT && HSELx && (HTRANS == HTRANS_NONSEQ)
		                      && HWRITE && (HADDR[4:2] == CRC_CR)))
		else $error("reset_chain raised outside a CR write");

endmodule

`default_nettype wire

// File: testbench/crc_ahb_tb.sv
/*
  Testbench of the AHB-Lite CRC accelerator
  Drives AHB transfers one at a time, derives every expected CRC with a
  reference model and compares each read in a separate process
*/
`default_nettype none

module crc_ahb_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import crc_pkg::*;

	localparam int BUF_DEPTH = 2;

	// Transfer counts per test set the watchdog limit
	localparam int SETUP_XFERS   = 3;
	localparam int CRC32_ROUNDS  = 3;
	localparam int CRC32_WORDS   = 5;
	localparam int MIX_WORDS     = 3;
	localparam int BURST_WORDS   = 3 * BUF_DEPTH + 1;
	localparam int PLANNED_XFERS = 12
		+ CRC32_ROUNDS * (SETUP_XFERS + CRC32_WORDS + 1)
		+ 8 * (SETUP_XFERS + MIX_WORDS + 1)
		+ 3 * (SETUP_XFERS + MIX_WORDS + 1)
		+ (SETUP_XFERS + BURST_WORDS + 1)
		+ (5 + MIX_WORDS + 1);

	// AHB signals
	logic     HCLK = 1'b0;
	logic     HRESETn;
	word_t    HADDR;
	word_t    HWDATA;
	hsize_t   HSIZE;
	htrans_t  HTRANS;
	logic     HWRITE;
	logic     HSELx;
	logic     HREADY;
	word_t    HRDATA;
	logic     HREADYOUT;
	logic     HRESP;

	// Pending checks filled by the stimulus and drained by the compare process
	string    name_q[$];
	word_t    exp_q[$];
	word_t    got_q[$];
	int       checks_issued = 0;
	int       checks_done = 0;

	// DR words of the current chain
	buf_entry_t sent_q[$];
	string      test_name = "none";
	int         seed = 32'h254a_f892;

	string    cmp_name;
	word_t    cmp_exp;
	word_t    cmp_got;

	always #4 HCLK = ~HCLK;

	crc_ahb_top #(
		.BUF_DEPTH (BUF_DEPTH)
	) i_crc_ahb_top (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HADDR     (HADDR),
		.HWDATA    (HWDATA),
		.HSIZE     (HSIZE),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSELx     (HSELx),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	bind crc_host_interface crc_ahb_assert i_host_assert (
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.HRESP       (HRESP),
		.HREADYOUT   (HREADYOUT),
		.HREADY      (HREADY),
		.HSELx       (HSELx),
		.HTRANS      (HTRANS),
		.HWRITE      (HWRITE),
		.HADDR       (HADDR),
		.reset_chain (reset_chain)
	);

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Low n bits of v in reverse order
	function automatic word_t reflect_bits(input word_t v, input int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++)
			r[n-1-i] = v[i];
		return r;
	endfunction

	// Reversal inside each byte, halfword or the whole word
	function automatic word_t reverse_input(input word_t d, input rev_in_t mode);
		int    span;
		word_t r;
		case (mode)
			2'd1:    span = 8;
			2'd2:    span = 16;
			2'd3:    span = 32;
			default: span = 0;
		endcase
		if (span == 0)
			return d;
		r = '0;
		for (int base = 0; base < 32; base += span)
			r = r | (reflect_bits(d >> base, span) << base);
		return r;
	endfunction

	// Non-reflected MSB-first CRC over the low bytes of each word taken lowest first
	function automatic word_t crc_ref(input word_t seed_v, input word_t poly,
	                                  input crc_cfg_t cfg, input buf_entry_t words[$]);
		int    width;
		int    nbytes;
		word_t mask;
		word_t crc;
		word_t d;
		byte_t b;
		logic  fb;
		case (cfg.poly_size)
			2'd1:    width = 16;
			2'd2:    width = 8;
			2'd3:    width = 7;
			default: width = 32;
		endcase
		mask = (width == 32) ? 32'hFFFF_FFFF : ((32'h1 << width) - 32'h1);
		crc  = seed_v & mask;
		foreach (words[k])
		begin
			d      = reverse_input(words[k].data, cfg.rev_in);
			nbytes = (words[k].size == 2'd0) ? 1 : ((words[k].size == 2'd1) ? 2 : 4);
			for (int j = 0; j < nbytes; j++)
			begin
				b = d[8*j +: 8];
				for (int i = 7; i >= 0; i--)
				begin
					fb  = crc[width-1] ^ b[i];
					crc = (crc << 1) & mask;
					if (fb)
						crc = crc ^ (poly & mask);
				end
			end
		end
		if (cfg.rev_out)
			crc = reflect_bits(crc, width);
		return crc;
	endfunction

	////////////////////////////////////////////////////////////
	// Helpers and AHB driver
	////////////////////////////////////////////////////////////

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	// Byte address of a register word offset
	function automatic word_t reg_addr(input reg_addr_t off);
		return {27'h0, off, 2'b00};
	endfunction

	// CR layout with poly size at [4:3], input reversal at [6:5] and output reversal at [7]
	function automatic word_t cr_word(input crc_cfg_t cfg, input logic restart);
		return {24'h0, cfg.rev_out, cfg.rev_in, cfg.poly_size, 2'b00, restart};
	endfunction

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1);
	endtask

	// Called just after a rising edge with the bus idle
	task automatic ahb_write(input word_t addr, input word_t data, input bus_size_t size);
		HSELx  <= 1'b1;
		HTRANS <= HTRANS_NONSEQ;
		HADDR  <= addr;
		HWRITE <= 1'b1;
		HSIZE  <= {1'b0, size};
		@(posedge HCLK);
		// Data phase
		HSELx  <= 1'b0;
		HTRANS <= 2'b00;
		HWDATA <= data;
		@(negedge HCLK);
		while (!HREADYOUT)
			@(negedge HCLK);
		@(posedge HCLK);
	endtask

	task automatic ahb_read(input word_t addr, output word_t data);
		HSELx  <= 1'b1;
		HTRANS <= HTRANS_NONSEQ;
		HADDR  <= addr;
		HWRITE <= 1'b0;
		HSIZE  <= 3'd2;
		@(posedge HCLK);
		HSELx  <= 1'b0;
		HTRANS <= 2'b00;
		// Read data is taken mid-cycle of the last data phase cycle
		@(negedge HCLK);
		while (!HREADYOUT)
			@(negedge HCLK);
		data = HRDATA;
		@(posedge HCLK);
	endtask

	// CR restart with an INIT write pipelined right behind it
	task automatic restart_then_init(input word_t cr, input word_t seed_v);
		HSELx  <= 1'b1;
		HTRANS <= HTRANS_NONSEQ;
		HADDR  <= reg_addr(CRC_CR);
		HWRITE <= 1'b1;
		HSIZE  <= 3'd2;
		@(posedge HCLK);
		HWDATA <= cr;
		HADDR  <= reg_addr(CRC_INIT);
		@(posedge HCLK);
		// INIT data phase meets the seed load
		HSELx  <= 1'b0;
		HTRANS <= 2'b00;
		HWDATA <= seed_v;
		@(negedge HCLK);
		while (!HREADYOUT)
			@(negedge HCLK);
		@(posedge HCLK);
	endtask

	task automatic check_reg(input string what, input word_t addr, input word_t expected);
		word_t got;
		ahb_read(addr, got);
		name_q.push_back({test_name, " ", what});
		exp_q.push_back(expected);
		got_q.push_back(got);
		checks_issued++;
	endtask

	task automatic start_chain(input word_t seed_v, input word_t poly, input crc_cfg_t cfg);
		ahb_write(reg_addr(CRC_INIT), seed_v, 2'd2);
		ahb_write(reg_addr(CRC_POL), poly, 2'd2);
		ahb_write(reg_addr(CRC_CR), cr_word(cfg, 1'b1), 2'd2);
		sent_q.delete();
	endtask

	task automatic write_dr(input word_t data, input bus_size_t size);
		buf_entry_t entry;
		entry.data = data;
		entry.size = size;
		ahb_write(reg_addr(CRC_DR), data, size);
		sent_q.push_back(entry);
	endtask

	// Byte, halfword and word writes in turn with random upper lanes
	task automatic write_mixed();
		for (int k = 0; k < MIX_WORDS; k++)
			write_dr(rand_word(), bus_size_t'(k % 3));
	endtask

	////////////////////////////////////////////////////////////
	// Compare process and watchdog
	////////////////////////////////////////////////////////////

	initial
	begin
		forever
		begin
			@(posedge HCLK);
			while (got_q.size() > 0)
			begin
				cmp_name = name_q.pop_front();
				cmp_exp  = exp_q.pop_front();
				cmp_got  = got_q.pop_front();
				assert (cmp_got == cmp_exp)
				else
					fail_run($sformatf("** Error %s: expected %08h, actual %08h",
					                   cmp_name, cmp_exp, cmp_got));
				checks_done++;
			end
		end
	end

	initial
	begin
		repeat (200 * PLANNED_XFERS)
			@(posedge HCLK);
		fail_run("Watchdog timeout: the tests did not finish in the expected time");
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial
	begin : stimulus
		crc_cfg_t cfg;
		word_t    seed_w;
		word_t    poly_w;
		word_t    r;
		HRESETn <= 1'b0;
		HADDR   <= '0;
		HWDATA  <= '0;
		HSIZE   <= 3'd2;
		HTRANS  <= 2'b00;
		HWRITE  <= 1'b0;
		HSELx   <= 1'b0;
		// Single slave so nothing else stretches the bus
		HREADY  <= 1'b1;
		repeat (5)
			@(posedge HCLK);
		HRESETn <= 1'b1;

		// Reset values and read-back
		test_name = "register_reset";
		check_reg("INIT", reg_addr(CRC_INIT), 32'hFFFF_FFFF);
		check_reg("POL", reg_addr(CRC_POL), 32'h04C1_1DB7);
		check_reg("IDR", reg_addr(CRC_IDR), 32'h0000_0000);
		check_reg("CR", reg_addr(CRC_CR), 32'h0000_0000);
		test_name = "register_rw";
		ahb_write(reg_addr(CRC_IDR), 32'h1234_56A5, 2'd2);
		check_reg("IDR", reg_addr(CRC_IDR), 32'h0000_00A5);
		ahb_write(reg_addr(CRC_CR), 32'hFFFF_FFFF, 2'd2);
		check_reg("CR", reg_addr(CRC_CR), 32'h0000_00F8);
		ahb_write(reg_addr(CRC_INIT), 32'h89AB_CDEF, 2'd2);
		check_reg("INIT", reg_addr(CRC_INIT), 32'h89AB_CDEF);
		ahb_write(reg_addr(CRC_POL), 32'h1EDC_6F41, 2'd2);
		check_reg("POL", reg_addr(CRC_POL), 32'h1EDC_6F41);

		// CRC-32 over full words with a new seed on every restart
		test_name = "crc32_restart";
		cfg = '0;
		for (int k = 0; k < CRC32_ROUNDS; k++)
		begin
			seed_w = rand_word();
			start_chain(seed_w, CRC_POL_RST, cfg);
			for (int w = 0; w < CRC32_WORDS; w++)
				write_dr(rand_word(), 2'd2);
			check_reg("DR", reg_addr(CRC_DR), crc_ref(seed_w, CRC_POL_RST, cfg, sent_q));
		end

		// All input reversal modes with and without output reversal
		test_name = "reversal_sizes";
		for (int m = 0; m < 8; m++)
		begin
			cfg.poly_size = 2'd0;
			cfg.rev_in    = rev_in_t'(m >> 1);
			cfg.rev_out   = m[0];
			seed_w = rand_word();
			start_chain(seed_w, CRC_POL_RST, cfg);
			write_mixed();
			check_reg("DR", reg_addr(CRC_DR), crc_ref(seed_w, CRC_POL_RST, cfg, sent_q));
		end

		// Narrow polynomials with random POL and reversal
		test_name = "narrow_poly";
		for (int ps = 1; ps < 4; ps++)
		begin
			r = rand_word();
			cfg.poly_size = poly_size_t'(ps);
			cfg.rev_in    = r[1:0];
			cfg.rev_out   = r[2];
			poly_w = rand_word() | 32'h1;
			seed_w = rand_word();
			start_chain(seed_w, poly_w, cfg);
			write_mixed();
			check_reg("DR", reg_addr(CRC_DR), crc_ref(seed_w, poly_w, cfg, sent_q));
		end

		// More words than the buffer holds and a DR read right after
		test_name = "buffer_stall";
		cfg = '0;
		seed_w = rand_word();
		start_chain(seed_w, CRC_POL_RST, cfg);
		for (int w = 0; w < BURST_WORDS; w++)
			write_dr(rand_word(), 2'd2);
		check_reg("DR", reg_addr(CRC_DR), crc_ref(seed_w, CRC_POL_RST, cfg, sent_q));

		// INIT write stalled by the seed load and used on the next restart
		test_name = "init_after_restart";
		ahb_write(reg_addr(CRC_POL), CRC_POL_RST, 2'd2);
		seed_w = rand_word();
		restart_then_init(cr_word(cfg, 1'b1), seed_w);
		check_reg("INIT", reg_addr(CRC_INIT), seed_w);
		ahb_write(reg_addr(CRC_CR), cr_word(cfg, 1'b1), 2'd2);
		sent_q.delete();
		write_mixed();
		check_reg("DR", reg_addr(CRC_DR), crc_ref(seed_w, CRC_POL_RST, cfg, sent_q));

		// Let the compare process drain
		wait (checks_done == checks_issued);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
hdl/crc_pkg.sv
hdl/crc_host_interface.sv
hdl/crc_data_buffer.sv
hdl/crc_engine.sv
hdl/crc_config_regs.sv
hdl/crc_ahb_top.sv
testbench/crc_ahb_assert.sv
testbench/crc_ahb_tb.sv

// File: Makefile
# Verilator build and run for the AHB-Lite CRC accelerator testbench

SIM       := verilator
TOP       := crc_ahb_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
LOG       := sim.log
FAIL_MSG  := tests failed
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Result: FAIL, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: run ended without a pass line, see $(LOG)"; exit 1; \
	else \
		echo "Result: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
